//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef enum logic [ 6 : 0 ] {
        opc_load   = 7'b0000011,                // lw
        opc_op_imm = 7'b0010011,                // I-type arithmetic
        opc_store  = 7'b0100011,                // sw
        opc_op     = 7'b0110011,                // R-type arithmetic
        opc_lui    = 7'b0110111,                // Load upper immediate
        opc_branch = 7'b1100011,                // beq, bne
        opc_jalr   = 7'b1100111,                // Indirect jump
        opc_jal    = 7'b1101111                 // Direct jump
    } opcode_e;

    typedef enum logic [ 1 : 0 ] {
        alu_op_mem    = 2'b00,                  // Address add
        alu_op_branch = 2'b01,                  // Compare by subtract
        alu_op_arith  = 2'b10,                  // Picked by funct3/funct7
        alu_op_upper  = 2'b11                   // lui, pass immediate
    } alu_op_e;

    typedef enum logic [ 3 : 0 ] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sll    = 4'd6,
        alu_srl    = 4'd7,
        alu_sra    = 4'd8,
        alu_pass_b = 4'd9                       // Operand b straight out
    } alu_ctrl_e;

    typedef enum logic [ 2 : 0 ] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_src_e;

    typedef struct packed {
        logic [ 6 : 0 ]  funct7;
        logic [ 4 : 0 ]  rs2;
        logic [ 4 : 0 ]  rs1;
        logic [ 2 : 0 ]  funct3;
        logic [ 4 : 0 ]  rd;
        opcode_e         opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [ 11 : 0 ] imm11_0;
        logic [ 4 : 0 ]  rs1;
        logic [ 2 : 0 ]  funct3;
        logic [ 4 : 0 ]  rd;
        opcode_e         opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [ 6 : 0 ]  imm11_5;
        logic [ 4 : 0 ]  rs2;
        logic [ 4 : 0 ]  rs1;
        logic [ 2 : 0 ]  funct3;
        logic [ 4 : 0 ]  imm4_0;
        opcode_e         opcode;
    } s_fmt_t;

    typedef struct packed {
        logic            imm12;                 // Sign bit
        logic [ 5 : 0 ]  imm10_5;
        logic [ 4 : 0 ]  rs2;
        logic [ 4 : 0 ]  rs1;
        logic [ 2 : 0 ]  funct3;
        logic [ 3 : 0 ]  imm4_1;
        logic            imm11;
        opcode_e         opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [ 19 : 0 ] imm31_12;
        logic [ 4 : 0 ]  rd;
        opcode_e         opcode;
    } u_fmt_t;

    typedef struct packed {
        logic            imm20;                 // Sign bit
        logic [ 9 : 0 ]  imm10_1;
        logic            imm11;
        logic [ 7 : 0 ]  imm19_12;
        logic [ 4 : 0 ]  rd;
        opcode_e         opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        logic      pc_src;                      // Branch or jal redirect
        logic      result_src;                  // Load data to rd
        logic      mem_write;
        logic      alu_src;                     // Immediate as operand b
        logic      reg_write;
        logic      jalr_pc_src;                 // Next PC from ALU
        logic      jstore;                      // PC plus 4 to rd
        alu_ctrl_e alu_ctrl;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic            reg_we;
        logic [ 4 : 0 ]  rd;
        logic [ 31 : 0 ] rd_data;
        logic            mem_we;
        logic [ 31 : 0 ] mem_addr;
        logic [ 31 : 0 ] mem_data;
    } retire_t;

endpackage

`default_nettype wire

//--- source/instr_mem.sv
`default_nettype none

module instr_mem #(

    parameter int WIDTH = 32,
    parameter int DEPTH = 256

) (

    input  logic                  clk_i,
    input  logic                  we_i,         // Load port write
    input  logic [ 31 : 0 ]       waddr_i,      // Byte address
    input  logic [ WIDTH - 1 : 0 ] wdata_i,
    input  logic [ 31 : 0 ]       addr_i,       // PC

    output logic [ WIDTH - 1 : 0 ] rd_o

);

localparam int AW = $clog2( DEPTH );            // Word index width

logic [ WIDTH - 1 : 0 ] mem [ DEPTH ];
logic                   rd_in_range;
logic                   wr_in_range;

assign rd_in_range = ( addr_i[ 31 : 2 ] < 30'( DEPTH ) );
assign wr_in_range = ( waddr_i[ 31 : 2 ] < 30'( DEPTH ) );

always_ff @( posedge clk_i ) begin
    if ( we_i && wr_in_range ) begin
        mem[ waddr_i[ AW + 1 : 2 ] ] <= wdata_i;  // Word write, low bits dropped
    end
end

// Fetch past the end of the array sees addi x0, x0, 0
assign rd_o = rd_in_range ? mem[ addr_i[ AW + 1 : 2 ] ] : WIDTH'( 32'h0000_0013 );

endmodule

`default_nettype wire

//--- source/main_decoder.sv
`default_nettype none

module main_decoder import cpu_pkg::*; (

    input  logic           eq_i,                // Zero flag from ALU
    input  opcode_e        op_i,
    input  logic [ 2 : 0 ] funct3_i,

    output logic           pc_src_o,            // PC plus immediate
    output logic           result_src_o,        // Load data to rd
    output logic           mem_write_o,
    output logic           alu_src_o,           // Immediate as operand b
    output imm_src_e       imm_src_o,
    output logic           reg_write_o,
    output logic           jalr_pc_src_o,       // Next PC from ALU result
    output alu_op_e        alu_op_o,
    output logic           jstore_o             // Write PC plus 4

);

logic branch_taken;

// beq on equal, bne on not equal, other funct3 never taken
always_comb begin
    case ( funct3_i )
        3'b000:  branch_taken = eq_i;
        3'b001:  branch_taken = !eq_i;
        default: branch_taken = 1'b0;
    endcase
end

always_comb begin
    pc_src_o      = 1'b0;                       // Defaults give a nop
    result_src_o  = 1'b0;
    mem_write_o   = 1'b0;
    alu_src_o     = 1'b0;
    imm_src_o     = imm_i;
    reg_write_o   = 1'b0;
    jalr_pc_src_o = 1'b0;
    alu_op_o      = alu_op_mem;
    jstore_o      = 1'b0;
    case ( op_i )
        opc_op: begin
            reg_write_o = 1'b1;
            alu_op_o    = alu_op_arith;
        end
        opc_op_imm: begin
            reg_write_o = 1'b1;
            alu_src_o   = 1'b1;
            alu_op_o    = alu_op_arith;
        end
        opc_load: begin
            reg_write_o  = 1'b1;
            alu_src_o    = 1'b1;
            result_src_o = 1'b1;                // rd from data memory
        end
        opc_store: begin
            mem_write_o = 1'b1;
            alu_src_o   = 1'b1;
            imm_src_o   = imm_s;
        end
        opc_branch: begin
            imm_src_o = imm_b;
            alu_op_o  = alu_op_branch;          // Subtract sets the flag
            pc_src_o  = branch_taken;
        end
        opc_jal: begin
            reg_write_o = 1'b1;
            imm_src_o   = imm_j;
            pc_src_o    = 1'b1;
            jstore_o    = 1'b1;
        end
        opc_jalr: begin
            reg_write_o   = 1'b1;
            alu_src_o     = 1'b1;               // Target is rs1 plus imm
            jalr_pc_src_o = 1'b1;
            jstore_o      = 1'b1;
        end
        opc_lui: begin
            reg_write_o = 1'b1;
            alu_src_o   = 1'b1;
            imm_src_o   = imm_u;
            alu_op_o    = alu_op_upper;
        end
        default: ;                              // Unknown opcode, no writes
    endcase
end

endmodule

`default_nettype wire

//--- source/alu_decoder.sv
`default_nettype none

module alu_decoder import cpu_pkg::*; (

    input  logic [ 2 : 0 ] funct3_i,
    input  logic           funct7_i,            // Instruction bit 30
    input  logic           op5_i,               // R-type when set
    input  alu_op_e        alu_op_i,

    output alu_ctrl_e      alu_control_o

);

always_comb begin
    case ( alu_op_i )
        alu_op_mem:    alu_control_o = alu_add;     // lw, sw, jalr
        alu_op_branch: alu_control_o = alu_sub;
        alu_op_upper:  alu_control_o = alu_pass_b;
        default: begin
            case ( funct3_i )
                // addi never subtracts, whatever bit 30 holds
                3'b000:  alu_control_o = ( funct7_i && op5_i ) ? alu_sub : alu_add;
                3'b001:  alu_control_o = alu_sll;
                3'b010:  alu_control_o = alu_slt;
                3'b100:  alu_control_o = alu_xor;
                3'b101:  alu_control_o = funct7_i ? alu_sra : alu_srl;
                3'b110:  alu_control_o = alu_or;
                3'b111:  alu_control_o = alu_and;
                default: alu_control_o = alu_add;   // sltu not supported
            endcase
        end
    endcase
end

endmodule

`default_nettype wire

//--- source/sign_extend.sv
`default_nettype none

module sign_extend import cpu_pkg::*; (

    input  logic [ 24 : 0 ] instr31_7_i,        // Instruction without opcode
    input  imm_src_e        imm_src_i,

    output logic [ 31 : 0 ] imm_ext_o

);

instr_u ins;                                    // Rebuilt word for field access

assign ins = { instr31_7_i, 7'b0 };             // Opcode bits unused here

always_comb begin
    case ( imm_src_i )
        imm_s: imm_ext_o = { { 20{ ins.s_fmt.imm11_5[ 6 ] } },
                             ins.s_fmt.imm11_5, ins.s_fmt.imm4_0 };
        imm_b: imm_ext_o = { { 20{ ins.b_fmt.imm12 } }, ins.b_fmt.imm11,
                             ins.b_fmt.imm10_5, ins.b_fmt.imm4_1, 1'b0 };
        imm_u: imm_ext_o = { ins.u_fmt.imm31_12, 12'b0 };   // Low bits zero
        imm_j: imm_ext_o = { { 12{ ins.j_fmt.imm20 } }, ins.j_fmt.imm19_12,
                             ins.j_fmt.imm11, ins.j_fmt.imm10_1, 1'b0 };
        default: imm_ext_o = { { 20{ ins.i_fmt.imm11_0[ 11 ] } },
                               ins.i_fmt.imm11_0 };          // I format
    endcase
end

endmodule

`default_nettype wire

//--- source/control_top.sv
`default_nettype none

module control_top import cpu_pkg::*; #(

    parameter int INSTR_WIDTH = 32,
    parameter int IMEM_DEPTH  = 256

) (

    input  logic              clk_i,
    input  logic              load_we_i,        // Program load strobe
    input  logic [ 31 : 0 ]   load_addr_i,      // Byte address of loaded word
    input  logic [ 31 : 0 ]   load_data_i,
    input  logic [ 31 : 0 ]   pc_i,             // Fetch address
    input  logic              eq_i,             // ALU zero flag

    output ctrl_t             ctrl_o,           // Datapath controls
    output logic [ 31 : 0 ]   imm_op_o,         // Extended immediate
    output instr_u            instr_o           // Fetched word, by format

);

logic [ INSTR_WIDTH - 1 : 0 ] fetch_word;       // Raw memory word
imm_src_e                     imm_src;          // Immediate format
alu_op_e                      alu_op;           // ALU use class

assign instr_o = 32'( fetch_word );             // Low 32 bits are the instruction

instr_mem #(
    .WIDTH   ( INSTR_WIDTH ),
    .DEPTH   ( IMEM_DEPTH )
) instr_mem (
    .clk_i   ( clk_i ),
    .we_i    ( load_we_i ),
    .waddr_i ( load_addr_i ),
    .wdata_i ( INSTR_WIDTH'( load_data_i ) ),
    .addr_i  ( pc_i ),
    .rd_o    ( fetch_word )
);

main_decoder main_decoder (
    .eq_i          ( eq_i ),
    .op_i          ( instr_o.r_fmt.opcode ),
    .funct3_i      ( instr_o.r_fmt.funct3 ),
    .pc_src_o      ( ctrl_o.pc_src ),
    .result_src_o  ( ctrl_o.result_src ),
    .mem_write_o   ( ctrl_o.mem_write ),
    .alu_src_o     ( ctrl_o.alu_src ),
    .imm_src_o     ( imm_src ),
    .reg_write_o   ( ctrl_o.reg_write ),
    .jalr_pc_src_o ( ctrl_o.jalr_pc_src ),
    .alu_op_o      ( alu_op ),
    .jstore_o      ( ctrl_o.jstore )
);

alu_decoder alu_decoder (
    .funct3_i      ( instr_o.r_fmt.funct3 ),
    .funct7_i      ( instr_o.r_fmt.funct7[ 5 ] ),  // Instruction bit 30
    .op5_i         ( instr_o.r_fmt.opcode[ 5 ] ),  // Set for R-type only
    .alu_op_i      ( alu_op ),
    .alu_control_o ( ctrl_o.alu_ctrl )
);

sign_extend sign_extend (
    .instr31_7_i ( instr_o[ 31 : 7 ] ),
    .imm_src_i   ( imm_src ),
    .imm_ext_o   ( imm_op_o )
);

endmodule

`default_nettype wire

//--- source/reg_file.sv
`default_nettype none

module reg_file (

    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            we_i,
    input  logic [ 4 : 0 ]  ra1_i,              // rs1
    input  logic [ 4 : 0 ]  ra2_i,              // rs2
    input  logic [ 4 : 0 ]  wa_i,               // rd
    input  logic [ 31 : 0 ] wd_i,

    output logic [ 31 : 0 ] rd1_o,
    output logic [ 31 : 0 ] rd2_o

);

logic [ 31 : 0 ] regs [ 32 ];

always_ff @( posedge clk_i ) begin
    if ( rst_n_i && we_i && ( wa_i != 5'd0 ) ) begin
        regs[ wa_i ] <= wd_i;                   // x0 never written
    end
end

assign rd1_o = ( ra1_i == 5'd0 ) ? 32'd0 : regs[ ra1_i ];  // x0 reads zero
assign rd2_o = ( ra2_i == 5'd0 ) ? 32'd0 : regs[ ra2_i ];

endmodule

`default_nettype wire

//--- source/alu.sv
`default_nettype none

module alu import cpu_pkg::*; (

    input  logic [ 31 : 0 ] a_i,                // rs1
    input  logic [ 31 : 0 ] b_i,                // rs2 or immediate
    input  alu_ctrl_e       ctrl_i,

    output logic [ 31 : 0 ] result_o,
    output logic            zero_o              // Equal compare for branches

);

logic [ 4 : 0 ] shamt;

assign shamt = b_i[ 4 : 0 ];

always_comb begin
    case ( ctrl_i )
        alu_add:    result_o = a_i + b_i;
        alu_sub:    result_o = a_i - b_i;
        alu_and:    result_o = a_i & b_i;
        alu_or:     result_o = a_i | b_i;
        alu_xor:    result_o = a_i ^ b_i;
        alu_slt:    result_o = { 31'd0, $signed( a_i ) < $signed( b_i ) };
        alu_sll:    result_o = a_i << shamt;
        alu_srl:    result_o = a_i >> shamt;
        alu_sra:    result_o = $unsigned( $signed( a_i ) >>> shamt );
        alu_pass_b: result_o = b_i;             // lui
        default:    result_o = 32'd0;
    endcase
end

assign zero_o = ( result_o == 32'd0 );

endmodule

`default_nettype wire

//--- source/data_mem.sv
`default_nettype none

module data_mem #(

    parameter int DEPTH = 256

) (

    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            we_i,
    input  logic [ 31 : 0 ] addr_i,             // Byte address from ALU
    input  logic [ 31 : 0 ] wd_i,

    output logic [ 31 : 0 ] rd_o

);

localparam int AW = $clog2( DEPTH );

logic [ 31 : 0 ] mem [ DEPTH ];

initial begin
    for ( int i = 0; i < DEPTH; i++ ) begin
        mem[ i ] = 32'd0;                       // Power-up contents
    end
end

always_ff @( posedge clk_i ) begin
    if ( rst_n_i && we_i ) begin
        mem[ addr_i[ AW + 1 : 2 ] ] <= wd_i;    // Upper address bits wrap
    end
end

assign rd_o = mem[ addr_i[ AW + 1 : 2 ] ];

endmodule

`default_nettype wire

//--- source/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; #(

    parameter int INSTR_WIDTH = 32,
    parameter int IMEM_DEPTH  = 256,
    parameter int DMEM_DEPTH  = 256

) (

    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            load_we_i,          // Program load port
    input  logic [ 31 : 0 ] load_addr_i,
    input  logic [ 31 : 0 ] load_data_i,

    output retire_t         retire_o            // Instruction about to commit

);

logic [ 31 : 0 ] pc;
logic [ 31 : 0 ] pc_next;
logic [ 31 : 0 ] pc_plus4;
logic [ 31 : 0 ] pc_target;                     // Branch and jal target
ctrl_t           ctrl;
logic [ 31 : 0 ] imm_op;
instr_u          instr;
logic [ 31 : 0 ] rs1_data;
logic [ 31 : 0 ] rs2_data;
logic [ 31 : 0 ] alu_b;
logic [ 31 : 0 ] alu_result;
logic            alu_zero;
logic [ 31 : 0 ] load_data;
logic [ 31 : 0 ] wb_data;                       // Value written to rd

always_ff @( posedge clk_i ) begin
    if ( !rst_n_i ) begin
        pc <= 32'd0;
    end else begin
        pc <= pc_next;
    end
end

assign pc_plus4  = pc + 32'd4;
assign pc_target = pc + imm_op;

always_comb begin
    if ( ctrl.jalr_pc_src ) begin
        pc_next = { alu_result[ 31 : 1 ], 1'b0 };   // jalr drops bit 0
    end else if ( ctrl.pc_src ) begin
        pc_next = pc_target;
    end else begin
        pc_next = pc_plus4;
    end
end

control_top #(
    .INSTR_WIDTH ( INSTR_WIDTH ),
    .IMEM_DEPTH  ( IMEM_DEPTH )
) control_top (
    .clk_i       ( clk_i ),
    .load_we_i   ( load_we_i ),
    .load_addr_i ( load_addr_i ),
    .load_data_i ( load_data_i ),
    .pc_i        ( pc ),
    .eq_i        ( alu_zero ),
    .ctrl_o      ( ctrl ),
    .imm_op_o    ( imm_op ),
    .instr_o     ( instr )
);

reg_file reg_file (
    .clk_i   ( clk_i ),
    .rst_n_i ( rst_n_i ),
    .we_i    ( ctrl.reg_write ),
    .ra1_i   ( instr.r_fmt.rs1 ),
    .ra2_i   ( instr.r_fmt.rs2 ),
    .wa_i    ( instr.r_fmt.rd ),
    .wd_i    ( wb_data ),
    .rd1_o   ( rs1_data ),
    .rd2_o   ( rs2_data )
);

assign alu_b = ctrl.alu_src ? imm_op : rs2_data;

alu alu (
    .a_i      ( rs1_data ),
    .b_i      ( alu_b ),
    .ctrl_i   ( ctrl.alu_ctrl ),
    .result_o ( alu_result ),
    .zero_o   ( alu_zero )
);

data_mem #(
    .DEPTH   ( DMEM_DEPTH )
) data_mem (
    .clk_i   ( clk_i ),
    .rst_n_i ( rst_n_i ),
    .we_i    ( ctrl.mem_write ),
    .addr_i  ( alu_result ),
    .wd_i    ( rs2_data ),
    .rd_o    ( load_data )
);

always_comb begin
    if ( ctrl.jstore ) begin
        wb_data = pc_plus4;                     // Link address
    end else if ( ctrl.result_src ) begin
        wb_data = load_data;
    end else begin
        wb_data = alu_result;
    end
end

// Retire record, quiet while reset holds the core
always_comb begin
    retire_o.valid    = rst_n_i;
    retire_o.reg_we   = rst_n_i && ctrl.reg_write;
    retire_o.rd       = instr.r_fmt.rd;
    retire_o.rd_data  = wb_data;
    retire_o.mem_we   = rst_n_i && ctrl.mem_write;
    retire_o.mem_addr = alu_result;
    retire_o.mem_data = rs2_data;               // Store data
end

endmodule

`default_nettype wire

//--- bench/cpu_checker.sv
`default_nettype none

module cpu_checker import cpu_pkg::*; #(

    parameter int NUM_ROWS = 1

) (

    input  logic    clk_i,
    input  retire_t retire_i,                   // Record about to commit
    input  retire_t exp_i [ NUM_ROWS ],         // Expected record per row
    input  logic    skip_i [ NUM_ROWS ],        // Rows a branch jumps over

    output logic    done_o,                     // Whole table walked
    output int      errors_o

);

timeunit 1ns;
timeprecision 1ps;

int   idx         = 0;                          // Next table row
int   n_pass      = 0;
int   n_fail      = 0;
int   n_reset_err = 0;                          // Write strobes seen in reset
logic done        = 1'b0;

assign done_o   = done;
assign errors_o = n_fail + n_reset_err;

function automatic string describe( input retire_t r );
    return $sformatf( "reg_we=%0b rd=x%0d data=%h mem_we=%0b addr=%h data=%h",
                      r.reg_we, r.rd, r.rd_data, r.mem_we, r.mem_addr, r.mem_data );
endfunction

task automatic compare_row( input int row, input retire_t got );
    retire_t want;
    logic    ok;
    want = exp_i[ row ];
    ok   = 1'b1;
    if ( got.reg_we !== want.reg_we || got.mem_we !== want.mem_we ) begin
        ok = 1'b0;
    end
    if ( want.reg_we && ( got.rd !== want.rd || got.rd_data !== want.rd_data ) ) begin
        ok = 1'b0;                              // Wrong target or value
    end
    if ( want.mem_we && ( got.mem_addr !== want.mem_addr ||
                          got.mem_data !== want.mem_data ) ) begin
        ok = 1'b0;
    end
    if ( ok ) begin
        n_pass++;
        $display( "row %0d ok: %s", row, describe( got ) );
    end else begin
        n_fail++;
        $display( "mismatch at %0d ns: row %0d want %s got %s",
                  $time, row, describe( want ), describe( got ) );
    end
endtask

// Sampled before the NBA updates of this edge land
always @( posedge clk_i ) begin
    if ( !retire_i.valid ) begin
        if ( retire_i.reg_we !== 1'b0 || retire_i.mem_we !== 1'b0 ) begin
            n_reset_err++;                      // Core held in reset
            $display( "mismatch at %0d ns: write strobe reported while in reset", $time );
        end
    end else if ( !done ) begin
        while ( idx < NUM_ROWS && skip_i[ idx ] ) begin
            idx++;                              // Leading skipped rows
        end
        compare_row( idx, retire_i );
        idx++;
        while ( idx < NUM_ROWS && skip_i[ idx ] ) begin
            idx++;                              // Jumped-over rows never retire
        end
        if ( idx >= NUM_ROWS ) begin
            $display( "checked %0d rows: %0d passed, %0d failed, %0d reset errors",
                      n_pass + n_fail, n_pass, n_fail, n_reset_err );
            done = 1'b1;
        end
    end
end

endmodule

`default_nettype wire

//--- bench/cpu_tb.sv
`default_nettype none

module cpu_tb import cpu_pkg::*; ( );

timeunit 1ns;
timeprecision 1ps;

localparam int NUM_ROWS        = 37;
localparam int CLK_PERIOD      = 20;
localparam int SETTLE_CYCLES   = 5;              // Reset held after the load
localparam int RESET_CYCLES    = NUM_ROWS + 1 + SETTLE_CYCLES;
localparam int WATCHDOG_CYCLES = NUM_ROWS + RESET_CYCLES + 20;

logic            clk;
logic            rst_n;
logic            load_we;
logic [ 31 : 0 ] load_addr;                      // Byte address
logic [ 31 : 0 ] load_data;
retire_t         retire;

logic [ 31 : 0 ] prog     [ NUM_ROWS ];          // Instruction words
retire_t         exp_tab  [ NUM_ROWS ];          // Expected retire record
logic            skip_tab [ NUM_ROWS ];          // Row a taken branch skips
int              n_rows;
logic [ 31 : 0 ] rng_state;
logic            table_ok;
logic            check_done;
int              check_errors;

function automatic logic [ 31 : 0 ] next_random( input logic [ 31 : 0 ] s );
    logic [ 31 : 0 ] x;
    x = s;
    x = x ^ ( x << 13 );
    x = x ^ ( x >> 17 );
    x = x ^ ( x << 5 );
    return x;
endfunction

function automatic logic [ 31 : 0 ] sext12( input logic [ 11 : 0 ] imm );
    return { { 20{ imm[ 11 ] } }, imm };
endfunction

function automatic logic [ 31 : 0 ] rtype( input logic [ 6 : 0 ] f7, input logic [ 4 : 0 ] rs2,
                                           input logic [ 4 : 0 ] rs1, input logic [ 2 : 0 ] f3,
                                           input logic [ 4 : 0 ] rd );
    return { f7, rs2, rs1, f3, rd, opc_op };
endfunction

function automatic logic [ 31 : 0 ] itype( input logic [ 11 : 0 ] imm, input logic [ 4 : 0 ] rs1,
                                           input logic [ 2 : 0 ] f3, input logic [ 4 : 0 ] rd,
                                           input logic [ 6 : 0 ] op );
    return { imm, rs1, f3, rd, op };
endfunction

function automatic logic [ 31 : 0 ] stype( input logic [ 11 : 0 ] imm, input logic [ 4 : 0 ] rs2,
                                           input logic [ 4 : 0 ] rs1 );
    return { imm[ 11 : 5 ], rs2, rs1, 3'b010, imm[ 4 : 0 ], opc_store };   // sw only
endfunction

function automatic logic [ 31 : 0 ] btype( input logic [ 12 : 0 ] imm, input logic [ 4 : 0 ] rs2,
                                           input logic [ 4 : 0 ] rs1, input logic [ 2 : 0 ] f3 );
    return { imm[ 12 ], imm[ 10 : 5 ], rs2, rs1, f3, imm[ 4 : 1 ], imm[ 11 ], opc_branch };
endfunction

function automatic logic [ 31 : 0 ] jtype( input logic [ 20 : 0 ] imm, input logic [ 4 : 0 ] rd );
    return { imm[ 20 ], imm[ 10 : 1 ], imm[ 11 ], imm[ 19 : 12 ], rd, opc_jal };
endfunction

task automatic add_row( input logic [ 31 : 0 ] word, input logic skip, input retire_t want );
    if ( n_rows < NUM_ROWS ) begin
        prog[ n_rows ]     = word;
        skip_tab[ n_rows ] = skip;
        exp_tab[ n_rows ]  = want;
    end
    n_rows++;                                   // Overflow caught by table_ok
endtask

task automatic write_row( input logic [ 31 : 0 ] word, input logic [ 4 : 0 ] rd,
                          input logic [ 31 : 0 ] value );
    retire_t want;
    want         = '0;
    want.valid   = 1'b1;
    want.reg_we  = 1'b1;
    want.rd      = rd;
    want.rd_data = value;
    add_row( word, 1'b0, want );
endtask

task automatic store_row( input logic [ 31 : 0 ] word, input logic [ 31 : 0 ] addr,
                          input logic [ 31 : 0 ] data );
    retire_t want;
    want          = '0;
    want.valid    = 1'b1;
    want.mem_we   = 1'b1;
    want.mem_addr = addr;
    want.mem_data = data;
    add_row( word, 1'b0, want );
endtask

task automatic quiet_row( input logic [ 31 : 0 ] word );
    retire_t want;
    want       = '0;
    want.valid = 1'b1;                          // Branch with no writes
    add_row( word, 1'b0, want );
endtask

task automatic skip_row( input logic [ 31 : 0 ] word );
    add_row( word, 1'b1, '0 );
endtask

// Row index times 4 is the PC of that row
task automatic build_program();
    logic [ 11 : 0 ] imm [ 4 ];
    logic [ 31 : 0 ] v1;
    logic [ 31 : 0 ] v2;
    logic [ 31 : 0 ] v4;
    logic [ 31 : 0 ] v22;
    logic [ 31 : 0 ] v24;
    logic [ 4 : 0 ]  sh;
    int              target;
    n_rows    = 0;
    rng_state = 32'h54ff9a3c;
    for ( int k = 0; k < 4; k++ ) begin
        rng_state = next_random( rng_state );
        imm[ k ]  = rng_state[ 11 : 0 ];
    end
    imm[ 0 ][ 11 ] = 1'b1;                      // Negative x1 so sra and slt see a sign bit
    v1 = sext12( imm[ 0 ] );
    v2 = sext12( imm[ 1 ] );
    v4 = v1 + v2;
    sh = v2[ 4 : 0 ];                           // Shift amount from rs2
    write_row( itype( imm[ 0 ], 5'd0, 3'b000, 5'd1, opc_op_imm ), 5'd1, v1 );
    write_row( itype( imm[ 1 ], 5'd0, 3'b000, 5'd2, opc_op_imm ), 5'd2, v2 );
    write_row( itype( imm[ 2 ], 5'd1, 3'b000, 5'd3, opc_op_imm ), 5'd3, v1 + sext12( imm[ 2 ] ) );
    write_row( rtype( 7'h00, 5'd2, 5'd1, 3'b000, 5'd4 ), 5'd4, v4 );
    write_row( rtype( 7'h20, 5'd2, 5'd1, 3'b000, 5'd5 ), 5'd5, v1 - v2 );
    write_row( rtype( 7'h00, 5'd2, 5'd1, 3'b111, 5'd6 ), 5'd6, v1 & v2 );
    write_row( rtype( 7'h00, 5'd2, 5'd1, 3'b110, 5'd7 ), 5'd7, v1 | v2 );
    write_row( rtype( 7'h00, 5'd2, 5'd1, 3'b100, 5'd8 ), 5'd8, v1 ^ v2 );
    write_row( rtype( 7'h00, 5'd2, 5'd1, 3'b010, 5'd9 ), 5'd9,
               ( $signed( v1 ) < $signed( v2 ) ) ? 32'd1 : 32'd0 );
    write_row( rtype( 7'h00, 5'd2, 5'd1, 3'b001, 5'd10 ), 5'd10, v1 << sh );
    write_row( rtype( 7'h00, 5'd2, 5'd1, 3'b101, 5'd11 ), 5'd11, v1 >> sh );
    write_row( rtype( 7'h20, 5'd2, 5'd1, 3'b101, 5'd12 ), 5'd12, $signed( v1 ) >>> sh );
    write_row( itype( imm[ 3 ], 5'd1, 3'b100, 5'd13, opc_op_imm ), 5'd13, v1 ^ sext12( imm[ 3 ] ) );
    write_row( itype( 12'h405, 5'd1, 3'b101, 5'd14, opc_op_imm ), 5'd14, $signed( v1 ) >>> 5 );
    write_row( itype( 12'h003, 5'd2, 3'b001, 5'd15, opc_op_imm ), 5'd15, v2 << 3 );
    write_row( itype( 12'd7, 5'd1, 3'b000, 5'd0, opc_op_imm ), 5'd0, v1 + 32'd7 );  // Into x0
    write_row( rtype( 7'h00, 5'd2, 5'd0, 3'b000, 5'd16 ), 5'd16, v2 );               // x0 reads 0
    store_row( stype( 12'd16, 5'd4, 5'd0 ), 32'd16, v4 );
    write_row( itype( 12'd16, 5'd0, 3'b010, 5'd17, opc_load ), 5'd17, v4 );
    write_row( itype( 12'd8, 5'd0, 3'b000, 5'd18, opc_op_imm ), 5'd18, 32'd8 );       // Base reg
    store_row( stype( 12'd12, 5'd1, 5'd18 ), 32'd20, v1 );
    write_row( itype( 12'd12, 5'd18, 3'b010, 5'd19, opc_load ), 5'd19, v1 );
    quiet_row( btype( 13'd8, 5'd4, 5'd17, 3'b000 ) );                    // beq taken
    skip_row( itype( 12'd1, 5'd0, 3'b000, 5'd20, opc_op_imm ) );
    quiet_row( btype( 13'd8, 5'd1, 5'd1, 3'b001 ) );                     // bne falls through
    write_row( itype( 12'd2, 5'd0, 3'b000, 5'd20, opc_op_imm ), 5'd20, 32'd2 );
    quiet_row( btype( 13'd8, 5'd0, 5'd20, 3'b001 ) );                    // bne taken
    skip_row( itype( 12'd3, 5'd0, 3'b000, 5'd20, opc_op_imm ) );
    quiet_row( btype( 13'd8, 5'd0, 5'd20, 3'b000 ) );                    // beq falls through
    write_row( { 20'hABCDE, 5'd21, opc_lui }, 5'd21, 32'hABCDE000 );
    v22 = 32'( ( n_rows + 1 ) * 4 );                                     // Link of jal
    write_row( jtype( 21'd8, 5'd22 ), 5'd22, v22 );
    skip_row( itype( 12'd4, 5'd0, 3'b000, 5'd20, opc_op_imm ) );
    target = ( n_rows + 3 ) * 4 + 1;            // Odd target that jalr rounds down
    write_row( itype( 12'( target ), 5'd0, 3'b000, 5'd23, opc_op_imm ), 5'd23, 32'( target ) );
    v24 = 32'( ( n_rows + 1 ) * 4 );
    write_row( itype( 12'd0, 5'd23, 3'b000, 5'd24, opc_jalr ), 5'd24, v24 );
    skip_row( itype( 12'd5, 5'd0, 3'b000, 5'd20, opc_op_imm ) );
    write_row( rtype( 7'h00, 5'd24, 5'd22, 3'b000, 5'd25 ), 5'd25, v22 + v24 );
    write_row( jtype( 21'd0, 5'd0 ), 5'd0, 32'( ( n_rows + 1 ) * 4 ) );  // Halt loop
endtask

cpu_top cpu_top_inst (
    .clk_i       ( clk ),
    .rst_n_i     ( rst_n ),
    .load_we_i   ( load_we ),
    .load_addr_i ( load_addr ),
    .load_data_i ( load_data ),
    .retire_o    ( retire )
);

cpu_checker #(
    .NUM_ROWS ( NUM_ROWS )
) cpu_checker_inst (
    .clk_i    ( clk ),
    .retire_i ( retire ),
    .exp_i    ( exp_tab ),
    .skip_i   ( skip_tab ),
    .done_o   ( check_done ),
    .errors_o ( check_errors )
);

initial begin
    clk = 1'b0;
    forever #( CLK_PERIOD / 2 ) clk = ~clk;
end

initial begin
    rst_n     = 1'b0;
    load_we   = 1'b0;
    load_addr = 32'd0;
    load_data = 32'd0;
    build_program();
    table_ok = ( n_rows == NUM_ROWS );
    if ( !table_ok ) begin
        $display( "program table holds %0d rows but %0d were declared", n_rows, NUM_ROWS );
    end
    for ( int i = 0; i < NUM_ROWS; i++ ) begin
        @( posedge clk );
        load_we   <= 1'b1;                      // One word per edge
        load_addr <= 32'( i * 4 );
        load_data <= prog[ i ];
    end
    @( posedge clk );
    load_we <= 1'b0;
    repeat ( SETTLE_CYCLES ) @( posedge clk );
    rst_n <= 1'b1;
    wait ( check_done );
    if ( table_ok && check_errors == 0 ) begin
        $display( "Simulation finished: PASS" );
    end else begin
        $display( "Simulation finished: FAIL" );
    end
    $finish;
end

// Load, settle and run must fit well inside this
initial begin
    #( WATCHDOG_CYCLES * CLK_PERIOD );
    $display( "timeout: the core did not retire all table rows within %0d cycles",
              WATCHDOG_CYCLES );
    $display( "Simulation finished: FAIL" );
    $finish;
end

endmodule

`default_nettype wire

//--- filelist.f
source/cpu_pkg.sv
source/instr_mem.sv
source/main_decoder.sv
source/alu_decoder.sv
source/sign_extend.sv
source/control_top.sv
source/reg_file.sv
source/alu.sv
source/data_mem.sv
source/cpu_top.sv
bench/cpu_checker.sv
bench/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the CPU testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
set -o pipefail

LOG=sim.log
rm -f "$LOG"

verilator --binary --top-module cpu_tb -Mdir obj_dir -f filelist.f \
    && ./obj_dir/Vcpu_tb 2>&1 | tee "$LOG" \
    || { echo "build or simulation step failed"; exit 1; }

grep -q "Simulation finished: FAIL" "$LOG" \
    && { echo "testbench reported failure, see $LOG"; exit 1; }

echo "run clean, log in $LOG"
exit 0
